/* vlog.f */
+incdir+hw
hw/dump_pkg.sv
hw/bit_sampler.sv
hw/sample_ram.sv
hw/ram_arbiter.sv
hw/hex_dumper.sv
hw/uart_tx.sv
hw/dump_apb_regs.sv
hw/sig_dump_top.sv
verification/sig_dump_assert.sv
verification/sig_dump_tb.sv

/* verification/sig_dump_tb.sv */
`include "dump_defs.svh"

module sig_dump_tb;
    import dump_pkg::*;

    localparam int N_WORDS   = 8;
    localparam int FRAME_CYC = 10 * `DUMP_BAUD_DIV;
    // capture plus two frames per word, doubled for handshake gaps and polling
    localparam int LIMIT = 2 * (N_WORDS * `DUMP_WORD_W + 2 * N_WORDS * FRAME_CYC) + 1000;

    logic                    clk, rst, sig;
    logic                    psel, penable, pwrite;
    logic [`DUMP_APB_AW-1:0] paddr;
    logic [31:0]             pwdata, prdata;
    logic                    pready, pslverr, tx_serial;
    logic [31:0]             lfsr;
    logic [31:0]             rd;
    int                      cycles;

    bind sig_dump_top sig_dump_assert u_chk (.*);

    sig_dump_top dut (.*);

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic apb_write(input logic [`DUMP_APB_AW-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1; // setup phase
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [`DUMP_APB_AW-1:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        data    = prdata; // held until the access edge
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        lfsr = lfsr_next(lfsr);
        sig  = lfsr[0]; // one step per sample
    end

    always @(negedge clk) begin
        cycles++;
        if (dut.u_chk.errors != 0) begin
            $display("TEST FAILED");
            $fatal(1, "an assertion check failed, see the error above");
        end else if (cycles >= LIMIT) begin
            $display("TEST FAILED");
            $fatal(1, "run timed out after %0d cycles without finishing", LIMIT);
        end
    end

    initial begin
        rst     = 1'b0;
        sig     = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        lfsr    = 32'h612d;
        cycles  = 0;
        repeat (8) @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);

        apb_write(REG_CTRL, 32'h1);
        repeat (N_WORDS * `DUMP_WORD_W - 3) @(negedge clk); // disable write adds 3 samples
        apb_write(REG_CTRL, 32'h0);
        repeat (4) @(negedge clk);
        apb_read(REG_COUNT, rd);

        apb_write(REG_CTRL, 32'h2);
        do begin
            apb_read(REG_STATUS, rd);
        end while (rd[0]); // wait for dump_busy to drop

        apb_write(REG_CTRL, 32'h4);
        apb_read(REG_COUNT, rd);
        apb_read(4'hc, rd); // unmapped offset
        repeat (4) @(negedge clk);

        if (dut.u_chk.errors == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "assertion errors were counted during the run");
        end
    end

endmodule

/* verification/sig_dump_assert.sv */
`include "dump_defs.svh"

module sig_dump_assert (
    input logic                    clk,
    input logic                    rst,
    input logic                    sig,
    input logic                    psel,
    input logic                    penable,
    input logic                    pwrite,
    input logic [`DUMP_APB_AW-1:0] paddr,
    input logic [31:0]             pwdata,
    input logic [31:0]             prdata,
    input logic                    pready,
    input logic                    pslverr,
    input logic                    dump_busy,
    input logic                    tx_serial
);
    import dump_pkg::*;

    localparam int BD       = `DUMP_BAUD_DIV;
    localparam int STOP_MID = 9 * BD + BD / 2;

    int                                errors = 0; // polled by the testbench
    logic                              ctrl_wr, cap_q, ser_q, rx_act;
    logic [$clog2(`DUMP_WORD_W)-1:0]   bit_q;
    word_t                             word_q;
    word_t                             mem_q [0:(1 << `DUMP_ADDR_W) - 1];
    count_t                            words_q, dump_words;
    int                                rx_cnt;
    logic [7:0]                        rx_byte, exp_byte;
    logic [9:0]                        n_bytes;

    assign ctrl_wr  = psel && penable && pwrite && paddr == 4'h0;
    assign exp_byte = n_bytes[0] ? mem_q[n_bytes[8:1]][7:0] : mem_q[n_bytes[8:1]][15:8];

    task automatic flag_error(input string what);
        $error("FAIL %0t: %s", $time, what);
        errors++;
    endtask

    // shadow of the capture, oldest sample lands in the msb
    always_ff @(posedge clk) begin
        if (!rst) begin
            cap_q   <= 1'b0;
            bit_q   <= '0;
            words_q <= '0;
        end else if (ctrl_wr && pwdata[2]) begin
            cap_q   <= pwdata[0];
            bit_q   <= '0;
            words_q <= '0; // memory keeps its words
        end else begin
            if (ctrl_wr) cap_q <= pwdata[0];
            if (cap_q && words_q < count_t'(1 << `DUMP_ADDR_W)) begin
                word_q <= {word_q[`DUMP_WORD_W-2:0], sig};
                bit_q  <= bit_q + 1'b1;
                if (bit_q == '1) begin
                    mem_q[words_q[`DUMP_ADDR_W-1:0]] <= {word_q[`DUMP_WORD_W-2:0], sig};
                    words_q <= words_q + 1'b1;
                end
            end
        end
    end

    // uart receiver, rx_cnt 0 is the first low sample
    always_ff @(posedge clk) begin
        ser_q <= tx_serial;
        if (!rst) begin
            rx_act <= 1'b0;
            rx_cnt <= 0;
        end else if (!rx_act) begin
            rx_act <= !tx_serial;
            rx_cnt <= 1;
        end else begin
            rx_cnt <= rx_cnt + 1;
            if (rx_cnt % BD == BD / 2 && rx_cnt > BD && rx_cnt < 9 * BD) begin
                rx_byte <= {tx_serial, rx_byte[7:1]}; // lsb first
            end
            if (rx_cnt == 10 * BD - 1) rx_act <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            dump_words <= '0;
            n_bytes    <= '0;
        end else if (ctrl_wr && pwdata[1] && !dump_busy && words_q != '0) begin
            dump_words <= words_q; // count frozen at start
            n_bytes    <= '0;
        end else if (rx_act && rx_cnt == STOP_MID) begin
            n_bytes <= n_bytes + 1'b1;
        end
    end

    a_reset_idle: assert property (@(posedge clk) $rose(rst) |-> tx_serial && !pslverr)
        else flag_error("line not idle or pslverr set after reset");
    a_pready: assert property (@(posedge clk) disable iff (!rst) psel && penable |-> pready)
        else flag_error("apb access completed without pready");
    a_pslverr: assert property (@(posedge clk) disable iff (!rst)
        psel && penable |-> pslverr == !(paddr inside {4'h0, 4'h4, 4'h8}))
        else flag_error("pslverr does not match the address decode");
    a_count: assert property (@(posedge clk) disable iff (!rst)
        psel && penable && !pwrite && paddr == 4'h8 |-> prdata == 32'(words_q))
        else flag_error("COUNT read differs from captured words");
    a_start_bit: assert property (@(posedge clk) disable iff (!rst)
        rx_act && rx_cnt == BD / 2 |-> !tx_serial)
        else flag_error("start bit not low at its middle");
    a_stop_bit: assert property (@(posedge clk) disable iff (!rst)
        rx_act && rx_cnt == STOP_MID |-> tx_serial)
        else flag_error("stop bit not high");
    a_bit_spacing: assert property (@(posedge clk) disable iff (!rst)
        rx_act && rx_cnt % BD != 0 |-> tx_serial == ser_q)
        else flag_error("tx_serial changed inside a bit period");
    a_byte: assert property (@(posedge clk) disable iff (!rst)
        rx_act && rx_cnt == STOP_MID |-> rx_byte == exp_byte)
        else flag_error("dumped byte differs from captured word");
    a_byte_total: assert property (@(posedge clk) disable iff (!rst)
        $fell(dump_busy) |-> n_bytes == 2 * dump_words)
        else flag_error("byte total is not twice the word count");

endmodule

/* hw/sig_dump_top.sv */
`include "dump_defs.svh"

module sig_dump_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sig,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`DUMP_APB_AW-1:0] paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    tx_serial
);
    import dump_pkg::*;

    logic       capture_en, dump_start, clear;
    logic       full, dump_busy;
    count_t     count;
    logic       wr_req, wr_gnt, rd_req, rd_gnt;
    addr_t      wr_addr, rd_addr, ram_addr;
    word_t      wr_data, rd_data, ram_wdata, ram_rdata;
    logic       ram_we;
    logic       tx_start, tx_busy;
    logic [7:0] tx_data;

    dump_apb_regs u_regs (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .dump_busy, .full, .count,
        .prdata, .pready, .pslverr, .capture_en, .dump_start, .clear
    );

    bit_sampler u_sampler (
        .clk, .rst, .sig, .capture_en, .clear, .wr_gnt,
        .wr_req, .wr_addr, .wr_data, .count, .full
    );

    ram_arbiter u_arb (
        .clk, .rst, .wr_req, .wr_addr, .wr_data, .rd_req, .rd_addr,
        .wr_gnt, .rd_gnt, .rd_data, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
    );

    sample_ram u_ram (
        .clk, .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata)
    );

    hex_dumper u_dumper (
        .clk, .rst, .dump_start, .count, .rd_gnt, .rd_data, .tx_busy,
        .rd_req, .rd_addr, .tx_start, .tx_data, .dump_busy
    );

    uart_tx u_uart (
        .clk, .rst, .tx_start, .tx_data, .tx_serial, .tx_busy
    );

endmodule

/* hw/dump_apb_regs.sv */
`include "dump_defs.svh"

module dump_apb_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`DUMP_APB_AW-1:0] paddr,
    input  logic [31:0]             pwdata,
    input  logic                    dump_busy,
    input  logic                    full,
    input  dump_pkg::count_t        count,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    capture_en,
    output logic                    dump_start,
    output logic                    clear
);
    import dump_pkg::*;

    logic access;
    logic hit;

    assign access  = psel && penable;
    assign hit     = (paddr == REG_CTRL) || (paddr == REG_STATUS) || (paddr == REG_COUNT);
    assign pready  = 1'b1; // zero wait states
    assign pslverr = access && !hit;

    always_ff @(posedge clk) begin
        if (!rst) begin
            capture_en <= 1'b0;
            dump_start <= 1'b0;
            clear      <= 1'b0;
        end else begin
            dump_start <= 1'b0;
            clear      <= 1'b0;
            if (access && pwrite && paddr == REG_CTRL) begin
                capture_en <= pwdata[0];
                dump_start <= pwdata[1]; // pulse, reads back 0
                clear      <= pwdata[2];
            end
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_CTRL:   prdata[0]   = capture_en;
            REG_STATUS: prdata[1:0] = {full, dump_busy};
            REG_COUNT:  prdata[`DUMP_ADDR_W:0] = count;
            default:    prdata = '0;
        endcase
    end

endmodule

/* hw/uart_tx.sv */
`include "dump_defs.svh"

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx_serial,
    output logic       tx_busy
);

    localparam int BAUD_W = $clog2(`DUMP_BAUD_DIV);
    localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`DUMP_BAUD_DIV - 1);

    logic [BAUD_W-1:0] baud_q;
    logic [3:0]        bit_q;   // 0 is the start bit, 9 the stop bit
    logic [9:0]        frame_q; // shifts out lsb first

    assign tx_serial = frame_q[0];

    always_ff @(posedge clk) begin
        if (!rst) begin
            baud_q  <= '0;
            bit_q   <= '0;
            frame_q <= '1; // line idles high
            tx_busy <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                frame_q <= {1'b1, tx_data, 1'b0};
                baud_q  <= '0;
                bit_q   <= '0;
                tx_busy <= 1'b1;
            end
        end else if (baud_q == BAUD_LAST) begin
            baud_q  <= '0;
            frame_q <= {1'b1, frame_q[9:1]}; // refill with idle level
            if (bit_q == 4'd9) begin
                tx_busy <= 1'b0; // stop bit done
            end else begin
                bit_q <= bit_q + 1'b1;
            end
        end else begin
            baud_q <= baud_q + 1'b1;
        end
    end

endmodule

/* hw/hex_dumper.sv */
module hex_dumper (
    input  logic             clk,
    input  logic             rst,
    input  logic             dump_start,
    input  dump_pkg::count_t count,
    input  logic             rd_gnt,
    input  dump_pkg::word_t  rd_data,
    input  logic             tx_busy,
    output logic             rd_req,
    output dump_pkg::addr_t  rd_addr,
    output logic             tx_start,
    output logic [7:0]       tx_data,
    output logic             dump_busy
);
    import dump_pkg::*;

    dump_state_e state_q;
    addr_t       addr_q;
    count_t      last_q;  // word count taken at dump start
    word_t       word_q;
    logic        tx_free; // uart idle and no start in flight

    assign rd_req    = (state_q == READ);
    assign rd_addr   = addr_q;
    assign tx_free   = !tx_busy && !tx_start;
    // stays high until the last stop bit is out
    assign dump_busy = (state_q != IDLE) || tx_start || tx_busy;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q  <= IDLE;
            addr_q   <= '0;
            last_q   <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0; // single-cycle pulse
            case (state_q)
                IDLE: begin
                    if (dump_start && !dump_busy && count != '0) begin
                        last_q  <= count;
                        addr_q  <= '0;
                        state_q <= READ;
                    end
                end
                READ: begin
                    if (rd_gnt) state_q <= WAIT_DATA; // writer may hold us off
                end
                WAIT_DATA: state_q <= SEND_HI;
                SEND_HI: begin
                    if (tx_free) begin
                        tx_start <= 1'b1;
                        state_q  <= SEND_LO;
                    end
                end
                SEND_LO: begin
                    if (tx_free) begin
                        tx_start <= 1'b1;
                        if (count_t'(addr_q) + 1'b1 == last_q) begin
                            state_q <= IDLE;
                        end else begin
                            addr_q  <= addr_q + 1'b1;
                            state_q <= READ;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // byte and word holding registers
    always_ff @(posedge clk) begin
        if (state_q == WAIT_DATA) word_q <= rd_data;
        if (state_q == SEND_HI && tx_free) tx_data <= word_q[15:8];
        if (state_q == SEND_LO && tx_free) tx_data <= word_q[7:0];
    end

endmodule

/* hw/ram_arbiter.sv */
module ram_arbiter (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr_req,
    input  dump_pkg::addr_t wr_addr,
    input  dump_pkg::word_t wr_data,
    input  logic            rd_req,
    input  dump_pkg::addr_t rd_addr,
    output logic            wr_gnt,
    output logic            rd_gnt,
    output dump_pkg::word_t rd_data,
    output logic            ram_we,
    output dump_pkg::addr_t ram_addr,
    output dump_pkg::word_t ram_wdata,
    input  dump_pkg::word_t ram_rdata
);
    import dump_pkg::*;

    logic  rd_pend_q; // read was granted last cycle
    word_t rd_hold_q;

    // fixed priority, capture never waits
    assign wr_gnt = wr_req;
    assign rd_gnt = rd_req && !wr_req;

    assign ram_we    = wr_gnt;
    assign ram_addr  = wr_gnt ? wr_addr : rd_addr;
    assign ram_wdata = wr_data;

    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= rd_gnt;
        end
    end

    // keeps the last read word stable once the writer takes the port
    always_ff @(posedge clk) begin
        if (rd_pend_q) begin
            rd_hold_q <= ram_rdata;
        end
    end

    assign rd_data = rd_pend_q ? ram_rdata : rd_hold_q;

endmodule

/* hw/sample_ram.sv */
`include "dump_defs.svh"

module sample_ram (
    input  logic            clk,
    input  logic            we,
    input  dump_pkg::addr_t addr,
    input  dump_pkg::word_t wdata,
    output dump_pkg::word_t rdata
);
    import dump_pkg::*;

    localparam int DEPTH = 1 << `DUMP_ADDR_W;

    word_t mem [0:DEPTH-1];

    // single shared port, read-first
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // valid the cycle after the access
    end

endmodule

/* hw/bit_sampler.sv */
`include "dump_defs.svh"

module bit_sampler (
    input  logic             clk,
    input  logic             rst,
    input  logic             sig,
    input  logic             capture_en,
    input  logic             clear,
    input  logic             wr_gnt,
    output logic             wr_req,
    output dump_pkg::addr_t  wr_addr,
    output dump_pkg::word_t  wr_data,
    output dump_pkg::count_t count,
    output logic             full
);
    import dump_pkg::*;

    localparam int BIT_W = $clog2(`DUMP_WORD_W);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`DUMP_WORD_W - 1);

    word_t            shift_q;
    logic [BIT_W-1:0] bit_cnt;
    logic             sampling;

    assign full     = count[`DUMP_ADDR_W];     // set only at 256
    assign wr_addr  = count[`DUMP_ADDR_W-1:0]; // next free word
    assign sampling = capture_en && !full;

    always_ff @(posedge clk) begin
        if (!rst) begin
            bit_cnt <= '0;
            count   <= '0;
            wr_req  <= 1'b0;
        end else if (clear) begin
            bit_cnt <= '0;
            count   <= '0; // memory contents left as they are
            wr_req  <= 1'b0;
        end else begin
            if (wr_req && wr_gnt) begin
                wr_req <= 1'b0;
                count  <= count + 1'b1;
            end
            if (sampling) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == LAST_BIT) begin
                    wr_req <= 1'b1;
                end
            end
        end
    end

    // payload path, no reset
    always_ff @(posedge clk) begin
        if (sampling) begin
            shift_q <= {shift_q[`DUMP_WORD_W-2:0], sig};
            if (bit_cnt == LAST_BIT) begin
                wr_data <= {shift_q[`DUMP_WORD_W-2:0], sig}; // oldest bit ends up in msb
            end
        end
    end

endmodule

/* hw/dump_pkg.sv */
`include "dump_defs.svh"

package dump_pkg;

    typedef logic [`DUMP_WORD_W-1:0] word_t;  // packed sample word
    typedef logic [`DUMP_ADDR_W-1:0] addr_t;
    typedef logic [`DUMP_ADDR_W:0]   count_t; // 0 to 256 words

    typedef enum logic [2:0] {
        IDLE,
        READ,      // request held until rd_gnt
        WAIT_DATA, // memory read latency
        SEND_HI,
        SEND_LO
    } dump_state_e;

    // apb register offsets
    localparam logic [`DUMP_APB_AW-1:0] REG_CTRL   = `DUMP_APB_AW'('h0);
    localparam logic [`DUMP_APB_AW-1:0] REG_STATUS = `DUMP_APB_AW'('h4);
    localparam logic [`DUMP_APB_AW-1:0] REG_COUNT  = `DUMP_APB_AW'('h8);

endpackage

/* hw/dump_defs.svh */
`ifndef DUMP_DEFS_SVH
`define DUMP_DEFS_SVH

// one word holds 16 samples of sig, oldest in the msb
`define DUMP_WORD_W   16

`define DUMP_ADDR_W   8  // 256 words of sample memory

// clocks per uart bit, so one 8N1 frame is 80 cycles
`define DUMP_BAUD_DIV 8

`define DUMP_APB_AW   4  // byte offsets 0x0 to 0xc

`endif
